// ==== src/recoveryTypes.sv ====
/*
 * Recovery type definitions.
 * Phase encoding of the recovery sequence, refetch types reported by the
 * register-write and commit stages, and trap cause codes for the trap CSR.
 */
package recoveryTypes;

    // commit -> recover0 -> recover1 -> commit
    typedef enum logic [1:0] {
        phaseCommit   = 2'd0,
        phaseRecover0 = 2'd1,
        phaseRecover1 = 2'd2
    } RecoveryPhase;

    // where fetch resumes after the flush
    typedef enum logic [2:0] {
        // redo the offending instruction
        refetchThisPc       = 3'd0,
        // resume right after it
        refetchNextPc       = 3'd1,
        // supplied pc is already the corrected target
        refetchBranchTarget = 3'd2,
        // trap before the instruction completes
        refetchThisPcToCsr  = 3'd3,
        // trap after completion, e.g. ecall
        refetchNextPcToCsr  = 3'd4
    } RefetchType;

    // subset of the machine cause codes
    typedef enum logic [3:0] {
        causeIllegalInsn = 4'd2,
        causeLoadFault   = 4'd5,
        causeStoreFault  = 4'd7,
        causeEcall       = 4'd11,
        // not a real cause, selects the return path
        causeMret        = 4'd15
    } TrapCause;

endpackage

// ==== src/coreParams.sv ====
/*
 * Core parameters.
 * Address and active-list widths, instruction size, the trap vector
 * after reset and the per-cycle rates of the rollback walkers.
 */
package coreParams;

    // pc and data address width
    localparam int addrWidth = 32;

    // active list has 64 entries, pointers wrap
    localparam int indexWidth = 6;

    // pc step for next-pc refetch
    localparam int insnBytes = 4;

    // trap vector value out of reset
    localparam logic [addrWidth-1:0] resetTrapVector = 32'h0000_0100;

    // rename map table walker rate
    localparam int rmtEntriesPerCycle = 2;

    // issue queue return walker rate
    localparam int iqEntriesPerCycle = 4;

endpackage

// ==== src/trapCsr.sv ====
/*
 * Trap CSR block.
 * Holds the trap vector and the saved exception pc, cause and fault value.
 * Answers a trap request with the redirect target in the same cycle and
 * records the trap state at the end of that cycle, except on a return.
 */
`timescale 1ns/1ps

module trapCsr (
    input  logic                               clock,
    input  logic                               rst,
    input  logic                               trapTrigger,
    input  recoveryTypes::TrapCause            trapCause,
    input  logic [coreParams::addrWidth-1:0]   trapPc,
    input  logic [coreParams::addrWidth-1:0]   trapValue,
    input  logic                               csrWriteEn,
    input  logic [coreParams::addrWidth-1:0]   csrWriteData,
    output logic [coreParams::addrWidth-1:0]   trapTarget,
    output logic [coreParams::addrWidth-1:0]   savedPc,
    output recoveryTypes::TrapCause            savedCause,
    output logic [coreParams::addrWidth-1:0]   savedValue
);
    import recoveryTypes::*;
    import coreParams::*;

    logic [addrWidth-1:0] trapVector;
    logic                 isReturn;

    assign isReturn = (trapCause == causeMret);

    // return goes back to the saved pc, everything else to the vector
    assign trapTarget = isReturn ? savedPc : trapVector;

    always_ff @(posedge clock) begin
        if (rst) begin
            trapVector <= resetTrapVector;
        end else if (csrWriteEn) begin
            // vector is word aligned
            trapVector <= {csrWriteData[addrWidth-1:2], 2'b00};
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            savedPc    <= '0;
            savedCause <= causeIllegalInsn;
            savedValue <= '0;
        end else if (trapTrigger && !isReturn) begin
            savedPc    <= trapPc;
            savedCause <= trapCause;
            savedValue <= trapValue;
        end
    end

endmodule

// ==== src/rollbackWalker.sv ====
/*
 * Rollback walker.
 * Loads the length of a wrapped active-list range on start and walks it
 * down by a fixed number of entries per cycle. Busy while entries remain.
 */
`timescale 1ns/1ps

module rollbackWalker #(
    parameter int entriesPerCycle = 1
) (
    input  logic                                clock,
    input  logic                                rst,
    input  logic                                start,
    input  logic [coreParams::indexWidth-1:0]   rangeHead,
    input  logic [coreParams::indexWidth-1:0]   rangeTail,
    output logic                                busy
);
    import coreParams::*;

    logic [indexWidth-1:0] rangeLength;
    logic [indexWidth-1:0] remaining;

    // modulo 64 by truncation
    assign rangeLength = rangeTail - rangeHead;

    always_ff @(posedge clock) begin
        if (rst) begin
            remaining <= '0;
        end else if (start) begin
            remaining <= rangeLength;
        end else if (int'(remaining) > entriesPerCycle) begin
            remaining <= remaining - indexWidth'(entriesPerCycle);
        end else begin
            // last partial step
            remaining <= '0;
        end
    end

    assign busy = (remaining != '0);

endmodule

// ==== src/recoveryManager.sv ====
/*
 * Recovery manager.
 * Registers exception and misprediction requests from the register-write
 * and commit stages and steps the commit, recover-0, recover-1 sequence.
 * Selects the refetch pc, drives the trap CSR in recover-0, computes the
 * flush range and waits on the walkers before returning to commit.
 */
`timescale 1ns/1ps

module recoveryManager (
    input  logic                                clock,
    input  logic                                rst,
    input  logic                                exceptionCommit,
    input  logic                                exceptionRw,
    input  recoveryTypes::RefetchType           refetchTypeCommit,
    input  recoveryTypes::RefetchType           refetchTypeRw,
    input  logic [coreParams::addrWidth-1:0]    pcCommit,
    input  logic [coreParams::addrWidth-1:0]    pcRw,
    input  recoveryTypes::TrapCause             trapCause,
    input  logic [coreParams::addrWidth-1:0]    faultAddr,
    input  logic [coreParams::indexWidth-1:0]   exceptionOpPtr,
    input  logic [coreParams::indexWidth-1:0]   flushTailPtr,
    input  logic                                rmtBusy,
    input  logic                                iqBusy,
    input  logic [coreParams::addrWidth-1:0]    trapTarget,
    output logic                                trapTrigger,
    output recoveryTypes::TrapCause             trapCauseOut,
    output logic [coreParams::addrWidth-1:0]    trapPc,
    output logic [coreParams::addrWidth-1:0]    trapValue,
    output recoveryTypes::RecoveryPhase         phase,
    output logic                                toRecoveryPhase,
    output logic                                toCommitPhase,
    output logic                                recoveryFromRw,
    output logic [coreParams::addrWidth-1:0]    recoveredPc,
    output logic [coreParams::indexWidth-1:0]   flushHeadPtr,
    output logic [coreParams::indexWidth-1:0]   flushTailPtrOut,
    output logic                                unableToStartRecovery
);
    import recoveryTypes::*;
    import coreParams::*;

    // everything captured at the request edge
    typedef struct packed {
        RecoveryPhase          phase;
        logic                  fromCommit;
        logic                  recoveryFromRw;
        RefetchType            refetchType;
        logic [addrWidth-1:0]  pcCommit;
        logic [addrWidth-1:0]  pcRw;
        TrapCause              trapCause;
        logic [addrWidth-1:0]  faultAddr;
        logic [indexWidth-1:0] flushHead;
        logic [indexWidth-1:0] flushTail;
    } ManagerState;

    ManagerState state;
    ManagerState nextState;

    logic                 requestSeen;
    RefetchType           requestType;
    logic                 refetchFromCsr;
    logic                 walkersBusy;
    logic [addrWidth-1:0] requestPc;

    always_ff @(posedge clock) begin
        if (rst) begin
            state.phase          <= phaseCommit;
            state.fromCommit     <= 1'b0;
            state.recoveryFromRw <= 1'b0;
            state.refetchType    <= refetchThisPc;
            state.flushHead      <= '0;
            state.flushTail      <= '0;
        end else begin
            state <= nextState;
        end
    end

    assign requestSeen = exceptionCommit || exceptionRw;
    assign walkersBusy = rmtBusy || iqBusy;

    // commit stage wins when both report in the same cycle
    assign requestType = exceptionCommit ? refetchTypeCommit : refetchTypeRw;

    always_comb begin
        nextState = state;
        case (state.phase)
            phaseCommit: begin
                if (requestSeen) begin
                    nextState.phase          = phaseRecover0;
                    nextState.fromCommit     = exceptionCommit;
                    nextState.recoveryFromRw = exceptionRw;
                    nextState.refetchType    = requestType;
                    nextState.pcCommit       = pcCommit;
                    nextState.pcRw           = pcRw;
                    nextState.trapCause      = trapCause;
                    nextState.faultAddr      = faultAddr;
                    // this-pc types flush the faulting op too
                    if (requestType inside {refetchThisPc, refetchThisPcToCsr}) begin
                        nextState.flushHead = exceptionOpPtr;
                    end else begin
                        nextState.flushHead = exceptionOpPtr + 1'b1;
                    end
                    nextState.flushTail = flushTailPtr;
                end
            end
            phaseRecover0: nextState.phase = phaseRecover1;
            default: begin
                if (toCommitPhase) begin
                    nextState.phase = phaseCommit;
                end
            end
        endcase
    end

    assign refetchFromCsr = state.refetchType inside {refetchThisPcToCsr, refetchNextPcToCsr};

    // trap requests only come from the commit stage
    assign trapTrigger  = (state.phase == phaseRecover0) && refetchFromCsr;
    assign trapCauseOut = state.trapCause;
    assign trapPc       = state.pcCommit;
    assign trapValue    = state.faultAddr;

    assign requestPc = state.fromCommit ? state.pcCommit : state.pcRw;

    // refetch pc is only meaningful in recover0
    always_comb begin
        recoveredPc = '0;
        if (state.phase == phaseRecover0) begin
            if (refetchFromCsr) begin
                recoveredPc = trapTarget;
            end else if (state.refetchType == refetchNextPc) begin
                recoveredPc = requestPc + addrWidth'(insnBytes);
            end else begin
                recoveredPc = requestPc;
            end
        end
    end

    assign phase           = state.phase;
    assign toRecoveryPhase = (state.phase == phaseRecover0);
    assign toCommitPhase   = (state.phase == phaseRecover1) && !walkersBusy;
    assign recoveryFromRw  = state.recoveryFromRw;
    assign flushHeadPtr    = state.flushHead;
    assign flushTailPtrOut = state.flushTail;

    assign unableToStartRecovery = (state.phase != phaseCommit) || walkersBusy;

endmodule

// ==== src/recoveryTop.sv ====
/*
 * Recovery subsystem top.
 * Ties the recovery manager to the trap CSR block and to the rename map
 * and issue queue rollback walkers that run side by side in recover-1.
 */
`timescale 1ns/1ps

module recoveryTop (
    input  logic                                clock,
    input  logic                                rst,
    input  logic                                exceptionCommit,
    input  logic                                exceptionRw,
    input  recoveryTypes::RefetchType           refetchTypeCommit,
    input  recoveryTypes::RefetchType           refetchTypeRw,
    input  logic [coreParams::addrWidth-1:0]    pcCommit,
    input  logic [coreParams::addrWidth-1:0]    pcRw,
    input  recoveryTypes::TrapCause             trapCause,
    input  logic [coreParams::addrWidth-1:0]    faultAddr,
    input  logic [coreParams::indexWidth-1:0]   exceptionOpPtr,
    input  logic [coreParams::indexWidth-1:0]   flushTailPtr,
    input  logic                                csrWriteEn,
    input  logic [coreParams::addrWidth-1:0]    csrWriteData,
    output recoveryTypes::RecoveryPhase         phase,
    output logic                                toRecoveryPhase,
    output logic                                toCommitPhase,
    output logic                                recoveryFromRw,
    output logic [coreParams::addrWidth-1:0]    recoveredPc,
    output logic [coreParams::indexWidth-1:0]   flushHeadPtr,
    output logic [coreParams::indexWidth-1:0]   flushTailPtrOut,
    output logic                                unableToStartRecovery,
    output logic [coreParams::addrWidth-1:0]    savedPc,
    output recoveryTypes::TrapCause             savedCause,
    output logic [coreParams::addrWidth-1:0]    savedValue
);
    import recoveryTypes::*;
    import coreParams::*;

    logic                 rmtBusy;
    logic                 iqBusy;
    logic                 trapTrigger;
    TrapCause             trapCauseOut;
    logic [addrWidth-1:0] trapPc;
    logic [addrWidth-1:0] trapValue;
    logic [addrWidth-1:0] trapTarget;

    recoveryManager manager (.*);

    trapCsr csr (
        .clock(clock), .rst(rst), .trapTrigger(trapTrigger), .trapCause(trapCauseOut),
        .trapPc(trapPc), .trapValue(trapValue), .csrWriteEn(csrWriteEn),
        .csrWriteData(csrWriteData), .trapTarget(trapTarget), .savedPc(savedPc),
        .savedCause(savedCause), .savedValue(savedValue)
    );

    // both walkers start on the recover0 pulse over the same range
    rollbackWalker #(.entriesPerCycle(rmtEntriesPerCycle)) rmtWalker (
        .clock(clock), .rst(rst), .start(toRecoveryPhase),
        .rangeHead(flushHeadPtr), .rangeTail(flushTailPtrOut), .busy(rmtBusy)
    );

    rollbackWalker #(.entriesPerCycle(iqEntriesPerCycle)) iqWalker (
        .clock(clock), .rst(rst), .start(toRecoveryPhase),
        .rangeHead(flushHeadPtr), .rangeTail(flushTailPtrOut), .busy(iqBusy)
    );

endmodule

// ==== testbench/tbClock.sv ====
/*
 * Testbench clock source.
 * Free-running clock with a 4 ns period.
 */
`timescale 1ns/1ps

module tbClock (
    output logic clock
);
    initial begin
        clock = 1'b0;
        forever begin
            #2 clock = ~clock;
        end
    end

endmodule

// ==== testbench/recoveryManager_assertions.sv ====
/*
 * Recovery manager assertions.
 * Phase pulses never overlap, recover-0 lasts one cycle and the
 * register-write stage never asks for a trap refetch.
 */
`timescale 1ns/1ps

module recoveryManagerAssertions (
    input logic                      clock,
    input logic                      rst,
    input logic                      toRecoveryPhase,
    input logic                      toCommitPhase,
    input logic                      exceptionRw,
    input recoveryTypes::RefetchType refetchTypeRw
);
    import recoveryTypes::*;

    pulsesExclusive: assert property (@(posedge clock) disable iff (rst)
        !(toRecoveryPhase && toCommitPhase))
        else $error("toRecoveryPhase and toCommitPhase are high in the same cycle");

    // traps are only reported at commit
    rwNeverTraps: assert property (@(posedge clock) disable iff (rst)
        exceptionRw |-> (refetchTypeRw != refetchThisPcToCsr
                         && refetchTypeRw != refetchNextPcToCsr))
        else $error("register-write request carries a trap refetch type");

    recover0SingleCycle: assert property (@(posedge clock) disable iff (rst)
        toRecoveryPhase |=> !toRecoveryPhase)
        else $error("toRecoveryPhase stayed high for two cycles");

endmodule

bind recoveryManager recoveryManagerAssertions checks (
    .clock(clock), .rst(rst), .toRecoveryPhase(toRecoveryPhase),
    .toCommitPhase(toCommitPhase), .exceptionRw(exceptionRw), .refetchTypeRw(refetchTypeRw)
);

// ==== testbench/recoveryTb.sv ====
/*
 * Testbench for the recovery subsystem.
 * Drives exception and misprediction requests, predicts the refetch pc,
 * flush range, trap CSR state and recovery length, and compares them
 * with the DUT at every recover-0 pulse.
 */
`timescale 1ns/1ps

module recoveryTb;
    import recoveryTypes::*;

    // walker rates, trap vector after reset, pc step and run length
    localparam int          rmtRate          = 2;
    localparam int          iqRate           = 4;
    localparam logic [31:0] vectorAfterReset = 32'h0000_0100;
    localparam logic [31:0] insnStep         = 32'd4;
    localparam int          requestCount     = 64;
    localparam int          timeoutCycles    = requestCount * 40 + 100;
    localparam TrapCause    causeTable [5]   = '{causeIllegalInsn, causeLoadFault,
                                                 causeStoreFault, causeEcall, causeMret};

    typedef struct packed {
        logic        commitValid;
        logic        rwValid;
        RefetchType  commitType;
        RefetchType  rwType;
        logic [31:0] commitPc;
        logic [31:0] rwPc;
        TrapCause    cause;
        logic [31:0] fault;
        logic [5:0]  opPtr;
        logic [5:0]  tailPtr;
    } Request;

    typedef struct packed {
        logic [31:0] vector;
        logic [31:0] pc;
        TrapCause    cause;
        logic [31:0] value;
    } CsrModel;

    typedef struct packed {
        logic [31:0] pc;
        logic        fromRw;
        logic [5:0]  head;
        logic [5:0]  tail;
        logic [7:0]  recover1Length;
        CsrModel     csr;
    } Expected;

    logic clock, rst, exceptionCommit, exceptionRw, csrWriteEn;
    RefetchType refetchTypeCommit, refetchTypeRw;
    TrapCause trapCause, savedCause;
    logic [31:0] pcCommit, pcRw, faultAddr, csrWriteData, recoveredPc, savedPc, savedValue;
    logic [5:0] exceptionOpPtr, flushTailPtr, flushHeadPtr, flushTailPtrOut;
    RecoveryPhase phase;
    logic toRecoveryPhase, toCommitPhase, recoveryFromRw, unableToStartRecovery;

    Expected     expectQueue [$];
    CsrModel     csrModel;
    logic [31:0] lfsrState = 32'h3e59_74a2;
    int          mismatchCount = 0;
    int          protocolErrors = 0;
    int          checkCount = 0;
    int          cycleCount = 0;
    int          requestsIssued = 0;

    tbClock clockGen (.clock(clock));

    recoveryTop u_dut (.*);

    function automatic logic [31:0] drawBits(input int width);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < width; i++) begin
            // fibonacci taps 32, 22, 2, 1
            lfsrState = {lfsrState[30:0],
                         lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
            value = {value[30:0], lfsrState[0]};
        end
        return value;
    endfunction

    function automatic Expected predictRecovery(input Request req, input CsrModel csr);
        Expected     want;
        RefetchType  kind;
        logic [31:0] pc;
        logic [5:0]  len;
        int          rmtCycles;
        int          iqCycles;
        kind = req.commitValid ? req.commitType : req.rwType;
        pc = req.commitValid ? req.commitPc : req.rwPc;
        want.fromRw = req.rwValid;
        want.csr = csr;
        if (kind == refetchThisPcToCsr || kind == refetchNextPcToCsr) begin
            if (req.cause == causeMret) begin
                want.pc = csr.pc;
            end else begin
                want.pc = csr.vector;
                want.csr.pc = req.commitPc;
                want.csr.cause = req.cause;
                want.csr.value = req.fault;
            end
        end else if (kind == refetchNextPc) begin
            want.pc = pc + insnStep;
        end else begin
            want.pc = pc;
        end
        want.head = (kind == refetchThisPc || kind == refetchThisPcToCsr) ?
                    req.opPtr : req.opPtr + 6'd1;
        want.tail = req.tailPtr;
        len = want.tail - want.head;
        rmtCycles = (int'(len) + rmtRate - 1) / rmtRate;
        iqCycles = (int'(len) + iqRate - 1) / iqRate;
        // walk cycles plus the closing recover-1 cycle
        want.recover1Length = 8'((rmtCycles > iqCycles ? rmtCycles : iqCycles) + 1);
        return want;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (expected !== actual) begin
            mismatchCount++;
            $display("CHECK FAILED %s: expected %0h, actual %0h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    task automatic waitIdle();
        while (unableToStartRecovery) begin
            @(posedge clock);
            #1;
        end
    endtask

    task automatic issueRequest(input Request req);
        Expected want;
        waitIdle();
        exceptionCommit = req.commitValid;
        exceptionRw = req.rwValid;
        refetchTypeCommit = req.commitType;
        refetchTypeRw = req.rwType;
        pcCommit = req.commitPc;
        pcRw = req.rwPc;
        trapCause = req.cause;
        faultAddr = req.fault;
        exceptionOpPtr = req.opPtr;
        flushTailPtr = req.tailPtr;
        want = predictRecovery(req, csrModel);
        expectQueue.push_back(want);
        csrModel = want.csr;
        requestsIssued++;
        @(posedge clock);
        #1;
        exceptionCommit = 1'b0;
        exceptionRw = 1'b0;
    endtask

    task automatic writeTrapVector(input logic [31:0] data);
        waitIdle();
        csrWriteEn = 1'b1;
        csrWriteData = data;
        csrModel.vector = {data[31:2], 2'b00};
        @(posedge clock);
        #1;
        csrWriteEn = 1'b0;
    endtask

    task automatic issueRandomRequest();
        Request      req;
        logic [31:0] pick;
        pick = drawBits(2);
        req.commitValid = (pick != 32'd2);
        req.rwValid = (pick >= 32'd2);
        req.commitType = RefetchType'(3'(drawBits(3) % 5));
        // register-write only reports non-trap types
        req.rwType = RefetchType'(3'(drawBits(2) % 3));
        req.commitPc = drawBits(30) << 2;
        req.rwPc = drawBits(30) << 2;
        req.cause = causeTable[3'(drawBits(3) % 5)];
        req.fault = drawBits(32);
        req.opPtr = 6'(drawBits(6));
        req.tailPtr = 6'(drawBits(6));
        issueRequest(req);
        repeat (drawBits(2)) begin
            @(posedge clock);
            #1;
        end
    endtask

    always begin : compareRecovery
        Expected want;
        int      cycles;
        @(negedge clock);
        if (!rst && toRecoveryPhase) begin
            if (expectQueue.size() == 0) begin
                protocolErrors++;
                $display("recover-0 pulse at %0t without an outstanding request", $time);
            end else begin
                want = expectQueue.pop_front();
                checkValue("recoveredPc", want.pc, recoveredPc);
                checkValue("flushHeadPtr", 32'(want.head), 32'(flushHeadPtr));
                checkValue("flushTailPtr", 32'(want.tail), 32'(flushTailPtrOut));
                checkValue("recoveryFromRw", 32'(want.fromRw), 32'(recoveryFromRw));
                checkValue("phaseRecover0", 32'(phaseRecover0), 32'(phase));
                cycles = 1;
                do begin
                    @(negedge clock);
                    cycles++;
                    checkValue("unableDuringRecovery", 32'd1, 32'(unableToStartRecovery));
                    checkValue("recoveredPcIdle", 32'd0, recoveredPc);
                end while (!toCommitPhase);
                checkValue("recoveryCycles", 32'(want.recover1Length) + 32'd1, 32'(cycles));
                checkValue("savedPc", want.csr.pc, savedPc);
                checkValue("savedCause", 32'(want.csr.cause), 32'(savedCause));
                checkValue("savedValue", want.csr.value, savedValue);
                @(negedge clock);
                checkValue("phaseBackToCommit", 32'(phaseCommit), 32'(phase));
                checkValue("unableAfterCommit", 32'd0, 32'(unableToStartRecovery));
            end
        end
    end

    initial begin : watchdog
        while (cycleCount < timeoutCycles) begin
            @(posedge clock);
            cycleCount++;
        end
        $display("timeout after %0d cycles, recovery never returned to the commit phase",
                 cycleCount);
        $display("TB FAILED");
        $finish;
    end

    initial begin : stimulus
        Request req;
        rst = 1'b1;
        exceptionCommit = 1'b0;
        exceptionRw = 1'b0;
        refetchTypeCommit = refetchThisPc;
        refetchTypeRw = refetchThisPc;
        pcCommit = '0;
        pcRw = '0;
        trapCause = causeIllegalInsn;
        faultAddr = '0;
        exceptionOpPtr = '0;
        flushTailPtr = '0;
        csrWriteEn = 1'b0;
        csrWriteData = '0;
        csrModel = '{vectorAfterReset, 32'h0, causeIllegalInsn, 32'h0};
        repeat (5) @(posedge clock);
        #1;
        rst = 1'b0;
        @(negedge clock);
        checkValue("resetPhase", 32'(phaseCommit), 32'(phase));
        checkValue("resetToRecovery", 32'd0, 32'(toRecoveryPhase));
        checkValue("resetToCommit", 32'd0, 32'(toCommitPhase));
        checkValue("resetRecoveredPc", 32'd0, recoveredPc);
        checkValue("resetUnable", 32'd0, 32'(unableToStartRecovery));
        @(posedge clock);
        #1;
        // trap straight out of reset lands on the reset vector
        req = '{1'b1, 1'b0, refetchThisPcToCsr, refetchThisPc, 32'h0000_2000, 32'h0,
                causeIllegalInsn, 32'hdead_beef, 6'd10, 6'd20};
        issueRequest(req);
        // return to the saved pc, saved state untouched
        req = '{1'b1, 1'b0, refetchThisPcToCsr, refetchThisPc, 32'h0000_3000, 32'h0,
                causeMret, 32'h0, 6'd4, 6'd8};
        issueRequest(req);
        writeTrapVector(32'h0000_8003);
        req = '{1'b1, 1'b0, refetchNextPcToCsr, refetchThisPc, 32'h0000_4004, 32'h0,
                causeEcall, 32'h0, 6'd30, 6'd31};
        issueRequest(req);
        // this-pc, next-pc and branch-target from commit, then from register-write
        for (int k = 0; k < 6; k++) begin
            req = '{k < 3, k >= 3, RefetchType'(3'(k % 3)), RefetchType'(3'(k % 3)),
                    32'h0000_5000 + 32'(k * 64), 32'h0001_0000 + 32'(k * 64),
                    causeLoadFault, 32'h0, 6'(k * 9), 6'(k * 9 + 12)};
            issueRequest(req);
        end
        // both stages in one cycle
        req = '{1'b1, 1'b1, refetchNextPc, refetchBranchTarget, 32'h0000_6000, 32'h0000_7000,
                causeStoreFault, 32'h0, 6'd40, 6'd50};
        issueRequest(req);
        // wrap-around at pointer 63, empty range and full range
        req = '{1'b1, 1'b0, refetchThisPc, refetchThisPc, 32'h0000_8100, 32'h0,
                causeLoadFault, 32'h0, 6'd63, 6'd5};
        issueRequest(req);
        req = '{1'b0, 1'b1, refetchThisPc, refetchNextPc, 32'h0, 32'h0000_8200,
                causeLoadFault, 32'h0, 6'd63, 6'd5};
        issueRequest(req);
        req = '{1'b0, 1'b1, refetchThisPc, refetchNextPc, 32'h0, 32'h0000_8300,
                causeLoadFault, 32'h0, 6'd62, 6'd63};
        issueRequest(req);
        req = '{1'b1, 1'b0, refetchThisPc, refetchThisPc, 32'h0000_8400, 32'h0,
                causeLoadFault, 32'h0, 6'd1, 6'd0};
        issueRequest(req);
        while (requestsIssued < requestCount) begin
            issueRandomRequest();
        end
        while (unableToStartRecovery || expectQueue.size() != 0) begin
            @(posedge clock);
            #1;
        end
        repeat (2) @(posedge clock);
        $display("recovery checks: %0d run, %0d mismatches, %0d protocol errors",
                 checkCount, mismatchCount, protocolErrors);
        if (mismatchCount == 0 && protocolErrors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
src/recoveryTypes.sv
src/coreParams.sv
src/trapCsr.sv
src/rollbackWalker.sv
src/recoveryManager.sv
src/recoveryTop.sv
testbench/tbClock.sv
testbench/recoveryManager_assertions.sv
testbench/recoveryTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the recovery subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module recoveryTb -o recoveryTbSim

output=$(./obj_dir/recoveryTbSim)
echo "$output"

if echo "$output" | grep -q "^TB PASSED$"; then
    exit 0
fi
exit 1
